//--- src/cpu_settings.svh
`ifndef CPU_SETTINGS_SVH
`define CPU_SETTINGS_SVH

// datapath and address width
`define CPU_XLEN 32

// instruction memory size in words, loaded while reset is held
`define CPU_IMEM_DEPTH 64

// data memory size in words
`define CPU_DMEM_DEPTH 32

// architectural registers, x0 reads as zero
`define CPU_REG_COUNT 32

// first fetch address after reset
`define CPU_PC_RESET 32'h0000_0000

`endif

//--- src/isa_pkg.sv
`include "cpu_settings.svh"

package isa_pkg;

    typedef logic [`CPU_XLEN-1:0] word_t;                     // one machine word
    typedef logic [$clog2(`CPU_REG_COUNT)-1:0] reg_addr_t;    // rs1, rs2, rd
    typedef logic [2:0] funct3_t;
    typedef logic [6:0] funct7_t;

    // major opcodes, only the supported subset
    typedef enum logic [6:0] {
        opc_op     = 7'b0110011,  // register-register alu
        opc_op_imm = 7'b0010011,  // register-immediate alu
        opc_load   = 7'b0000011,
        opc_store  = 7'b0100011,
        opc_branch = 7'b1100011,
        opc_jal    = 7'b1101111,
        opc_jalr   = 7'b1100111,
        opc_system = 7'b1110011   // ecall
    } opcode_t;

    // funct3 values for op and op_imm
    localparam funct3_t f3_add_sub = 3'b000;
    localparam funct3_t f3_slt     = 3'b010;
    localparam funct3_t f3_or      = 3'b110;
    localparam funct3_t f3_and     = 3'b111;

    // funct3 for memory, branch and system
    localparam funct3_t f3_word   = 3'b010; // lw / sw
    localparam funct3_t f3_beq    = 3'b000;
    localparam funct3_t f3_priv   = 3'b000; // ecall

    // funct7 for op, bit 5 picks sub
    localparam funct7_t f7_base = 7'b0000000;
    localparam funct7_t f7_sub  = 7'b0100000;

    // addi x0, x0, 0
    localparam word_t nop_instr = 32'h0000_0013;

endpackage

//--- src/pipe_pkg.sv
`include "cpu_settings.svh"

package pipe_pkg;

    // alu operation, beq reuses sub for its zero test
    typedef enum logic [2:0] {
        alu_add = 3'd0,
        alu_sub = 3'd1,
        alu_and = 3'd2,
        alu_or  = 3'd3,
        alu_slt = 3'd4
    } alu_op_t;

    // source of the register write data
    typedef enum logic [1:0] {
        wb_alu       = 2'd0,
        wb_mem       = 2'd1,
        wb_pc_plus_4 = 2'd2  // jal / jalr link
    } wb_sel_t;

    // decoded control, all zero means no effect
    typedef struct packed {
        logic    rf_wr_en;    // already cleared for rd == x0
        alu_op_t alu_op;
        logic    alu_use_imm;
        logic    branch;      // beq
        logic    jump;        // jal or jalr
        logic    jalr;        // target from alu sum
        logic    mem_wr_en;   // sw
        wb_sel_t wb_sel;
        logic    halt;        // ecall
    } ctrl_t;

    // ==================================================================
    // stage registers
    // ==================================================================
    typedef struct packed {
        logic          valid;
        isa_pkg::word_t instr;
        isa_pkg::word_t pc;
    } if_id_t;

    typedef struct packed {
        logic              valid;
        ctrl_t             ctrl;
        isa_pkg::word_t    rs1_data;
        isa_pkg::word_t    rs2_data;
        isa_pkg::word_t    imm;
        isa_pkg::word_t    pc;
        isa_pkg::reg_addr_t rs1;
        isa_pkg::reg_addr_t rs2;
        isa_pkg::reg_addr_t rd;
    } id_ex_t;

    typedef struct packed {
        logic              valid;
        logic              rf_wr_en;
        logic              mem_wr_en;
        wb_sel_t           wb_sel;
        logic              halt;
        isa_pkg::word_t    alu_result;  // also the memory address
        isa_pkg::word_t    store_data;
        isa_pkg::reg_addr_t rd;
        isa_pkg::word_t    pc_plus_4;
    } ex_mem_t;

    typedef struct packed {
        logic              valid;
        logic              rf_wr_en;
        wb_sel_t           wb_sel;
        isa_pkg::word_t    alu_result;
        isa_pkg::word_t    mem_data;
        isa_pkg::reg_addr_t rd;
        isa_pkg::word_t    pc_plus_4;
        logic              halt;
    } mem_wb_t;

endpackage

//--- src/rf_write_if.sv
`timescale 1ns/1ps

// one register file write result, used for forwarding and writeback
interface rf_write_if;

    logic               valid;  // real instruction, not a bubble
    logic               wr_en;  // writes rd, never x0
    isa_pkg::reg_addr_t rd;
    isa_pkg::word_t     data;

    modport source (
        output valid, wr_en, rd, data
    );

    modport sink (
        input valid, wr_en, rd, data
    );

endinterface

//--- src/fetch_stage.sv
`timescale 1ns/1ps
`include "cpu_settings.svh"

module fetch_stage (
    input  logic             clk,
    input  logic             arst_n,
    input  logic             imem_wr_en,     // program load strobe, reset held
    input  isa_pkg::word_t   imem_wr_addr,   // byte address, word aligned
    input  isa_pkg::word_t   imem_wr_data,
    input  logic             redirect,       // taken beq / jump in execute
    input  isa_pkg::word_t   redirect_pc,
    input  logic             halt_seen,      // ecall decoded, stop fetching
    output pipe_pkg::if_id_t if_id
);

    localparam int imem_aw = $clog2(`CPU_IMEM_DEPTH);

    isa_pkg::word_t imem [`CPU_IMEM_DEPTH];
    isa_pkg::word_t pc;
    isa_pkg::word_t instr;

    // ==================================================================
    // instruction memory
    // ==================================================================
    always_ff @(posedge clk) begin
        if (imem_wr_en)
            imem[imem_wr_addr[imem_aw+1:2]] <= imem_wr_data;
    end

    assign instr = imem[pc[imem_aw+1:2]];   // async read, word index

    // ==================================================================
    // pc and fetch/decode register
    // ==================================================================
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            pc          <= `CPU_PC_RESET;
            if_id.valid <= 1'b0;
            if_id.instr <= isa_pkg::nop_instr;
            if_id.pc    <= `CPU_PC_RESET;
        end else if (redirect) begin
            pc          <= redirect_pc;         // target fetched next edge
            if_id.valid <= 1'b0;                // wrong-path slot killed
            if_id.instr <= isa_pkg::nop_instr;
            if_id.pc    <= pc;
        end else if (halt_seen) begin
            if_id.valid <= 1'b0;                // pc frozen, bubbles only
            if_id.instr <= isa_pkg::nop_instr;
            if_id.pc    <= pc;
        end else begin
            pc          <= pc + 32'd4;
            if_id.valid <= 1'b1;
            if_id.instr <= instr;
            if_id.pc    <= pc;
        end
    end

endmodule

//--- src/decode_stage.sv
`timescale 1ns/1ps
`include "cpu_settings.svh"

module decode_stage (
    input  logic             clk,
    input  logic             arst_n,
    input  pipe_pkg::if_id_t if_id,
    input  logic             flush,      // taken branch / jump in execute
    rf_write_if.sink         wb,         // registered writeback result
    output pipe_pkg::id_ex_t id_ex,
    output logic             halt_seen
);

    isa_pkg::word_t     instr;
    isa_pkg::opcode_t   opcode;
    isa_pkg::funct3_t   funct3;
    isa_pkg::funct7_t   funct7;
    isa_pkg::reg_addr_t rs1, rs2, rd;
    isa_pkg::word_t     imm_i, imm_s, imm_b, imm_j, imm;
    isa_pkg::word_t     rs1_data, rs2_data;
    pipe_pkg::ctrl_t    ctrl;
    logic               ecall_now;
    logic               halt_q;
    isa_pkg::word_t     regs [`CPU_REG_COUNT];

    assign instr  = if_id.instr;
    assign opcode = isa_pkg::opcode_t'(instr[6:0]);
    assign funct3 = instr[14:12];
    assign funct7 = instr[31:25];
    assign rd     = instr[11:7];
    assign rs1    = instr[19:15];
    assign rs2    = instr[24:20];

    // immediates, all sign extended from bit 31
    assign imm_i = {{20{instr[31]}}, instr[31:20]};
    assign imm_s = {{20{instr[31]}}, instr[31:25], instr[11:7]};
    assign imm_b = {{19{instr[31]}}, instr[31], instr[7], instr[30:25], instr[11:8], 1'b0};
    assign imm_j = {{11{instr[31]}}, instr[31], instr[19:12], instr[20], instr[30:21], 1'b0};

    // ==================================================================
    // decoder
    // ==================================================================
    always_comb begin
        ctrl = '0;      // unknown encodings do nothing
        imm  = imm_i;
        case (opcode)
            isa_pkg::opc_op: begin
                ctrl.rf_wr_en = 1'b1;
                case (funct3)
                    isa_pkg::f3_add_sub: ctrl.alu_op = (funct7 == isa_pkg::f7_sub) ?
                                                       pipe_pkg::alu_sub : pipe_pkg::alu_add;
                    isa_pkg::f3_slt:     ctrl.alu_op = pipe_pkg::alu_slt;
                    isa_pkg::f3_or:      ctrl.alu_op = pipe_pkg::alu_or;
                    isa_pkg::f3_and:     ctrl.alu_op = pipe_pkg::alu_and;
                    default:             ctrl.rf_wr_en = 1'b0;
                endcase
            end
            isa_pkg::opc_op_imm: begin
                ctrl.rf_wr_en    = 1'b1;
                ctrl.alu_use_imm = 1'b1;
                case (funct3)
                    isa_pkg::f3_add_sub: ctrl.alu_op = pipe_pkg::alu_add;
                    isa_pkg::f3_slt:     ctrl.alu_op = pipe_pkg::alu_slt;
                    isa_pkg::f3_or:      ctrl.alu_op = pipe_pkg::alu_or;
                    isa_pkg::f3_and:     ctrl.alu_op = pipe_pkg::alu_and;
                    default:             ctrl.rf_wr_en = 1'b0;
                endcase
            end
            isa_pkg::opc_load: begin
                ctrl.rf_wr_en    = (funct3 == isa_pkg::f3_word);
                ctrl.alu_use_imm = 1'b1;                    // address = rs1 + imm
                ctrl.wb_sel      = pipe_pkg::wb_mem;
            end
            isa_pkg::opc_store: begin
                ctrl.mem_wr_en   = (funct3 == isa_pkg::f3_word);
                ctrl.alu_use_imm = 1'b1;
                imm              = imm_s;
            end
            isa_pkg::opc_branch: begin
                ctrl.branch = (funct3 == isa_pkg::f3_beq);
                ctrl.alu_op = pipe_pkg::alu_sub;            // zero means equal
                imm         = imm_b;
            end
            isa_pkg::opc_jal: begin
                ctrl.rf_wr_en = 1'b1;
                ctrl.jump     = 1'b1;
                ctrl.wb_sel   = pipe_pkg::wb_pc_plus_4;
                imm           = imm_j;
            end
            isa_pkg::opc_jalr: begin
                ctrl.rf_wr_en    = 1'b1;
                ctrl.jump        = 1'b1;
                ctrl.jalr        = 1'b1;
                ctrl.alu_use_imm = 1'b1;
                ctrl.wb_sel      = pipe_pkg::wb_pc_plus_4;
            end
            isa_pkg::opc_system: ctrl.halt = (funct3 == isa_pkg::f3_priv);
            default: ;
        endcase
        ctrl.rf_wr_en = ctrl.rf_wr_en & (rd != '0);        // x0 is never written
    end

    // ==================================================================
    // register file
    // ==================================================================
    always_ff @(posedge clk) begin
        if (wb.wr_en)
            regs[wb.rd] <= wb.data;
    end

    // same-cycle writeback bypasses the array
    always_comb begin
        rs1_data = (rs1 == '0) ? '0 : regs[rs1];
        rs2_data = (rs2 == '0) ? '0 : regs[rs2];
        if (wb.valid && wb.wr_en && wb.rd == rs1)
            rs1_data = wb.data;
        if (wb.valid && wb.wr_en && wb.rd == rs2)
            rs2_data = wb.data;
    end

    // halt_seen acts in the ecall's own decode cycle, then stays set
    assign ecall_now = if_id.valid & ~flush & ctrl.halt;
    assign halt_seen = halt_q | ecall_now;

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            halt_q <= 1'b0;
            id_ex  <= '0;
        end else begin
            if (ecall_now)
                halt_q <= 1'b1;
            id_ex.valid    <= if_id.valid & ~flush;                 // flush -> bubble
            id_ex.ctrl     <= (if_id.valid && !flush) ? ctrl : '0;
            id_ex.rs1_data <= rs1_data;
            id_ex.rs2_data <= rs2_data;
            id_ex.imm      <= imm;
            id_ex.pc       <= if_id.pc;
            id_ex.rs1      <= rs1;
            id_ex.rs2      <= rs2;
            id_ex.rd       <= rd;
        end
    end

endmodule

//--- src/execute_stage.sv
`timescale 1ns/1ps

module execute_stage (
    input  logic              clk,
    input  logic              arst_n,
    input  pipe_pkg::id_ex_t  id_ex,
    rf_write_if.sink          mem_fwd,     // result now in memory stage
    rf_write_if.sink          wb_fwd,      // registered writeback result
    output logic              redirect,
    output isa_pkg::word_t    redirect_pc,
    output pipe_pkg::ex_mem_t ex_mem
);

    isa_pkg::word_t op_a;       // rs1 after forwarding
    isa_pkg::word_t rs2_val;    // rs2 after forwarding, also store data
    isa_pkg::word_t op_b;
    isa_pkg::word_t alu_result;
    isa_pkg::word_t pc_plus_4;
    logic           zero;
    logic           taken;

    // memory stage is younger so it wins over writeback
    function automatic isa_pkg::word_t fwd_sel(
        input isa_pkg::reg_addr_t rs,
        input isa_pkg::word_t     reg_val,
        input logic               m_hit_en,
        input isa_pkg::reg_addr_t m_rd,
        input isa_pkg::word_t     m_data,
        input logic               w_hit_en,
        input isa_pkg::reg_addr_t w_rd,
        input isa_pkg::word_t     w_data
    );
        if (m_hit_en && m_rd == rs)
            return m_data;
        else if (w_hit_en && w_rd == rs)
            return w_data;
        return reg_val;
    endfunction

    // ==================================================================
    // operand forwarding and alu
    // ==================================================================
    assign op_a = fwd_sel(id_ex.rs1, id_ex.rs1_data,
                          mem_fwd.valid & mem_fwd.wr_en, mem_fwd.rd, mem_fwd.data,
                          wb_fwd.valid & wb_fwd.wr_en, wb_fwd.rd, wb_fwd.data);
    assign rs2_val = fwd_sel(id_ex.rs2, id_ex.rs2_data,
                             mem_fwd.valid & mem_fwd.wr_en, mem_fwd.rd, mem_fwd.data,
                             wb_fwd.valid & wb_fwd.wr_en, wb_fwd.rd, wb_fwd.data);
    assign op_b = id_ex.ctrl.alu_use_imm ? id_ex.imm : rs2_val;

    always_comb begin
        case (id_ex.ctrl.alu_op)
            pipe_pkg::alu_sub: alu_result = op_a - op_b;
            pipe_pkg::alu_and: alu_result = op_a & op_b;
            pipe_pkg::alu_or:  alu_result = op_a | op_b;
            pipe_pkg::alu_slt: alu_result = {31'd0, $signed(op_a) < $signed(op_b)};
            default:           alu_result = op_a + op_b;
        endcase
    end

    assign zero      = (alu_result == '0);
    assign pc_plus_4 = id_ex.pc + 32'd4;

    // ==================================================================
    // branch / jump resolution
    // ==================================================================
    assign taken       = id_ex.valid & ((id_ex.ctrl.branch & zero) | id_ex.ctrl.jump);
    assign redirect    = taken;
    assign redirect_pc = id_ex.ctrl.jalr ? {alu_result[31:1], 1'b0}   // jalr clears bit 0
                                         : id_ex.pc + id_ex.imm;      // beq, jal

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            ex_mem <= '0;
        end else begin
            ex_mem.valid      <= id_ex.valid;
            ex_mem.rf_wr_en   <= id_ex.ctrl.rf_wr_en;
            ex_mem.mem_wr_en  <= id_ex.ctrl.mem_wr_en;
            ex_mem.wb_sel     <= id_ex.ctrl.wb_sel;
            ex_mem.halt       <= id_ex.ctrl.halt;
            ex_mem.alu_result <= alu_result;
            ex_mem.store_data <= rs2_val;
            ex_mem.rd         <= id_ex.rd;
            ex_mem.pc_plus_4  <= pc_plus_4;
        end
    end

endmodule

//--- src/memory_stage.sv
`timescale 1ns/1ps
`include "cpu_settings.svh"

module memory_stage (
    input  logic              clk,
    input  logic              arst_n,
    input  pipe_pkg::ex_mem_t ex_mem,
    rf_write_if.source        mem_result,  // current stage, forwarded to execute
    rf_write_if.source        wb_result,   // registered, goes to the register file
    output logic              halt
);

    localparam int dmem_aw = $clog2(`CPU_DMEM_DEPTH);

    isa_pkg::word_t    dmem [`CPU_DMEM_DEPTH];
    isa_pkg::word_t    load_data;
    pipe_pkg::mem_wb_t mem_wb;
    logic              halt_q;

    function automatic isa_pkg::word_t wb_select(
        input pipe_pkg::wb_sel_t sel,
        input isa_pkg::word_t    alu,
        input isa_pkg::word_t    mem,
        input isa_pkg::word_t    link
    );
        case (sel)
            pipe_pkg::wb_mem:       return mem;
            pipe_pkg::wb_pc_plus_4: return link;
            default:                return alu;
        endcase
    endfunction

    // word-aligned data memory, async read
    always_ff @(posedge clk) begin
        if (ex_mem.valid && ex_mem.mem_wr_en)
            dmem[ex_mem.alu_result[dmem_aw+1:2]] <= ex_mem.store_data;
    end

    assign load_data = dmem[ex_mem.alu_result[dmem_aw+1:2]];

    assign mem_result.valid = ex_mem.valid;
    assign mem_result.wr_en = ex_mem.valid & ex_mem.rf_wr_en;
    assign mem_result.rd    = ex_mem.rd;
    assign mem_result.data  = wb_select(ex_mem.wb_sel, ex_mem.alu_result, load_data,
                                        ex_mem.pc_plus_4);

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            mem_wb <= '0;
            halt_q <= 1'b0;
        end else begin
            mem_wb.valid      <= ex_mem.valid;
            mem_wb.rf_wr_en   <= ex_mem.rf_wr_en;
            mem_wb.wb_sel     <= ex_mem.wb_sel;
            mem_wb.alu_result <= ex_mem.alu_result;
            mem_wb.mem_data   <= load_data;
            mem_wb.rd         <= ex_mem.rd;
            mem_wb.pc_plus_4  <= ex_mem.pc_plus_4;
            mem_wb.halt       <= ex_mem.halt;
            if (mem_wb.valid && mem_wb.halt)
                halt_q <= 1'b1;     // held until reset
        end
    end

    assign wb_result.valid = mem_wb.valid;
    assign wb_result.wr_en = mem_wb.valid & mem_wb.rf_wr_en;
    assign wb_result.rd    = mem_wb.rd;
    assign wb_result.data  = wb_select(mem_wb.wb_sel, mem_wb.alu_result, mem_wb.mem_data,
                                       mem_wb.pc_plus_4);

    assign halt = halt_q | (mem_wb.valid & mem_wb.halt);   // ecall in writeback

endmodule

//--- src/riscv_cpu.sv
`timescale 1ns/1ps
`include "cpu_settings.svh"

module riscv_cpu (
    input  logic                 clk,
    input  logic                 arst_n,
    input  logic                 imem_wr_en,    // program load, only while in reset
    input  logic [`CPU_XLEN-1:0] imem_wr_addr,
    input  logic [`CPU_XLEN-1:0] imem_wr_data,
    output logic                 halt,
    output logic                 commit_valid,  // one strobe per register write
    output logic [4:0]           commit_rd,
    output logic [`CPU_XLEN-1:0] commit_data
);

    pipe_pkg::if_id_t  if_id;
    pipe_pkg::id_ex_t  id_ex;
    pipe_pkg::ex_mem_t ex_mem;
    logic              redirect;
    isa_pkg::word_t    redirect_pc;
    logic              halt_seen;

    rf_write_if mem_result ();
    rf_write_if wb_result ();

    // ==================================================================
    // stages
    // ==================================================================
    fetch_stage u_fetch (
        .clk          (clk),
        .arst_n       (arst_n),
        .imem_wr_en   (imem_wr_en),
        .imem_wr_addr (imem_wr_addr),
        .imem_wr_data (imem_wr_data),
        .redirect     (redirect),
        .redirect_pc  (redirect_pc),
        .halt_seen    (halt_seen),
        .if_id        (if_id)
    );

    decode_stage u_decode (
        .clk       (clk),
        .arst_n    (arst_n),
        .if_id     (if_id),
        .flush     (redirect),      // same redirect kills the decode slot
        .wb        (wb_result),
        .id_ex     (id_ex),
        .halt_seen (halt_seen)
    );

    execute_stage u_execute (
        .clk         (clk),
        .arst_n      (arst_n),
        .id_ex       (id_ex),
        .mem_fwd     (mem_result),
        .wb_fwd      (wb_result),
        .redirect    (redirect),
        .redirect_pc (redirect_pc),
        .ex_mem      (ex_mem)
    );

    memory_stage u_memory (
        .clk        (clk),
        .arst_n     (arst_n),
        .ex_mem     (ex_mem),
        .mem_result (mem_result),
        .wb_result  (wb_result),
        .halt       (halt)
    );

    // commit port mirrors the register file write
    assign commit_valid = wb_result.wr_en;
    assign commit_rd    = wb_result.rd;
    assign commit_data  = wb_result.data;

endmodule

//--- testbench/tb_riscv_cpu.sv
`timescale 1ns/1ps
`include "cpu_settings.svh"

module tb_riscv_cpu;

    localparam int reset_cycles   = 8;   // extra reset cycles after the program load
    localparam int commit_timeout = 40;  // max cycles from one commit to the next
    localparam int halt_timeout   = 20;  // max cycles from last commit to halt
    localparam int quiet_window   = 30;  // cycles watched after halt

    logic               clk;
    logic               arst_n;
    logic               imem_wr_en;
    isa_pkg::word_t     imem_wr_addr;
    isa_pkg::word_t     imem_wr_data;
    logic               halt;
    logic               commit_valid;
    isa_pkg::reg_addr_t commit_rd;
    isa_pkg::word_t     commit_data;

    isa_pkg::reg_addr_t exp_rd_q [$];     // expected commits in program order
    isa_pkg::word_t     exp_data_q [$];

    riscv_cpu dut (
        .clk          (clk),
        .arst_n       (arst_n),
        .imem_wr_en   (imem_wr_en),
        .imem_wr_addr (imem_wr_addr),
        .imem_wr_data (imem_wr_data),
        .halt         (halt),
        .commit_valid (commit_valid),
        .commit_rd    (commit_rd),
        .commit_data  (commit_data)
    );

    always #2 clk = ~clk;   // 4 ns period

    // ======================================================================
    // failure reporting and compare tasks
    // ======================================================================
    task automatic report_failure(input string what);
        $display("%s", what);
        $display("Simulation FAILED");
        $fatal(1, "stopped at the first error");
    endtask

    task automatic check_commit(input isa_pkg::reg_addr_t exp_rd,
                                input isa_pkg::reg_addr_t got_rd);
        if (got_rd !== exp_rd)
            report_failure($sformatf("mismatch at time %0t: commit_rd expected x%0d got x%0d",
                                     $time, exp_rd, got_rd));
    endtask

    task automatic check_data(input isa_pkg::word_t exp_data, input isa_pkg::word_t got_data);
        if (got_data !== exp_data)
            report_failure($sformatf(
                "mismatch at time %0t: commit_data expected 0x%08h got 0x%08h",
                $time, exp_data, got_data));
    endtask

    task automatic check_halt(input logic exp_halt, input logic got_halt);
        if (got_halt !== exp_halt)
            report_failure($sformatf("mismatch at time %0t: halt expected %0b got %0b",
                                     $time, exp_halt, got_halt));
    endtask

    // ======================================================================
    // background fill of the whole instruction memory
    // ======================================================================
    // addi x31, x0, <byte address>
    // a stray fetch outside the program commits x31 with its own address
    function automatic isa_pkg::word_t fill_word(input isa_pkg::word_t addr);
        return {addr[11:0], 5'd0, 3'b000, 5'd31, 7'b0010011};
    endfunction

    task automatic fill_imem();
        isa_pkg::word_t addr;
        for (int i = 0; i < `CPU_IMEM_DEPTH; i++) begin
            addr = i * 4;
            @(negedge clk);
            imem_wr_en   = 1'b1;
            imem_wr_addr = addr;
            imem_wr_data = fill_word(addr);
        end
    endtask

    // ======================================================================
    // program load while reset is held
    // ======================================================================
    task automatic load_program();
        int             fd;
        int             n;
        int             words;
        int             rd_val;
        string          line;
        logic [7:0]     tag;
        isa_pkg::word_t addr_val;
        isa_pkg::word_t word_val;
        words = 0;
        fd = $fopen("testbench/program_input.txt", "r");
        if (fd == 0)
            report_failure("could not open testbench/program_input.txt for reading");
        while (!$feof(fd)) begin
            line = "";
            n = $fgets(line, fd);
            if (n > 0 && line.getc(0) == "I") begin
                n = $sscanf(line, "%c %h %h", tag, addr_val, word_val);
                if (n != 3)
                    report_failure($sformatf("bad program line in data file: %s", line));
                @(negedge clk);             // strobe driven on the falling edge
                imem_wr_en   = 1'b1;
                imem_wr_addr = addr_val;
                imem_wr_data = word_val;
                words++;
            end else if (n > 0 && line.getc(0) == "E") begin
                n = $sscanf(line, "%c %d %h", tag, rd_val, word_val);
                if (n != 3)
                    report_failure($sformatf("bad expectation line in data file: %s", line));
                exp_rd_q.push_back(rd_val[4:0]);
                exp_data_q.push_back(word_val);
            end
            // comment and blank lines fall through
        end
        $fclose(fd);
        @(negedge clk);
        imem_wr_en = 1'b0;                  // strobe ends after the last word
        if (words == 0 || exp_rd_q.size() == 0)
            report_failure("data file holds no program words or no expected commits");
    endtask

    // ======================================================================
    // commit, halt and post-halt checks
    // ======================================================================
    task automatic check_commits();
        int                 idle;
        isa_pkg::reg_addr_t exp_rd;
        isa_pkg::word_t     exp_data;
        while (exp_rd_q.size() > 0) begin
            exp_rd   = exp_rd_q.pop_front();
            exp_data = exp_data_q.pop_front();
            idle     = 0;
            @(negedge clk);                 // outputs settled mid-cycle
            while (!commit_valid) begin
                check_halt(1'b0, halt);     // halt only after every older commit
                idle++;
                if (idle > commit_timeout)
                    report_failure($sformatf("timeout: commit of x%0d never came", exp_rd));
                @(negedge clk);
            end
            check_halt(1'b0, halt);
            check_commit(exp_rd, commit_rd);
            check_data(exp_data, commit_data);
        end
    endtask

    task automatic wait_for_halt();
        int idle;
        idle = 0;
        @(negedge clk);
        while (!halt) begin
            if (commit_valid)
                report_failure($sformatf(
                    "unexpected commit of x%0d at time %0t after the last one",
                    commit_rd, $time));
            idle++;
            if (idle > halt_timeout)
                report_failure("timeout: halt never rose after the last commit");
            @(negedge clk);
        end
    endtask

    task automatic watch_after_halt();
        repeat (quiet_window) begin
            if (commit_valid)
                report_failure($sformatf("commit of x%0d at time %0t after halt",
                                         commit_rd, $time));
            check_halt(1'b1, halt);         // sticky until reset
            @(negedge clk);
        end
    endtask

    // ======================================================================
    // run sequence
    // ======================================================================
    initial begin
        clk          = 1'b0;
        arst_n       = 1'b0;
        imem_wr_en   = 1'b0;
        imem_wr_addr = '0;
        imem_wr_data = '0;
        fill_imem();
        load_program();                     // reset held through the load
        repeat (reset_cycles) @(negedge clk);
        check_halt(1'b0, halt);
        if (commit_valid)
            report_failure("commit strobe seen while reset was held");
        arst_n = 1'b1;                      // released on a falling edge
        check_commits();
        wait_for_halt();
        watch_after_halt();
        $display("Simulation PASSED");
        $finish;
    end

endmodule

//--- testbench/program_input.txt
# I <byte address hex> <instruction hex>   one instruction memory write
# E <rd decimal> <value hex>               next expected commit, program order
I 00000000 00600093  # addi x1, x0, 6
I 00000004 00B00113  # addi x2, x0, 11
I 00000008 002081B3  # add  x3, x1, x2     mem and wb forward
I 0000000C 40118233  # sub  x4, x3, x1
I 00000010 0041F2B3  # and  x5, x3, x4
I 00000014 0012E333  # or   x6, x5, x1
I 00000018 003223B3  # slt  x7, x4, x3
I 0000001C FFD00413  # addi x8, x0, -3
I 00000020 001424B3  # slt  x9, x8, x1     signed compare
I 00000024 FFF0A513  # slti x10, x1, -1
I 00000028 0F047593  # andi x11, x8, 0xf0
I 0000002C 7000E613  # ori  x12, x1, 0x700
I 00000030 04000693  # addi x13, x0, 0x40
I 00000034 0046A223  # sw   x4, 4(x13)
I 00000038 0046A703  # lw   x14, 4(x13)
I 0000003C 001707B3  # add  x15, x14, x1   load result used next
I 00000040 00378663  # beq  x15, x3, +12   taken
I 00000044 06300813  # addi x16, x0, 99    flushed
I 00000048 06200893  # addi x17, x0, 98    flushed
I 0000004C 00208463  # beq  x1, x2, +8     not taken
I 00000050 02100913  # addi x18, x0, 33
I 00000054 00C009EF  # jal  x19, +12
I 00000058 04D00A13  # addi x20, x0, 77    flushed
I 0000005C 04C00A93  # addi x21, x0, 76    flushed
I 00000060 07000B93  # addi x23, x0, 0x70
I 00000064 000B8B67  # jalr x22, 0(x23)
I 00000068 03700C13  # addi x24, x0, 55    flushed
I 0000006C 03600C93  # addi x25, x0, 54    flushed
I 00000070 013B0D33  # add  x26, x22, x19
I 00000074 00000073  # ecall
E 1 00000006
E 2 0000000B
E 3 00000011
E 4 0000000B
E 5 00000001
E 6 00000007
E 7 00000001
E 8 FFFFFFFD
E 9 00000001
E 10 00000000
E 11 000000F0
E 12 00000706
E 13 00000040
E 14 0000000B
E 15 00000011
E 18 00000021
E 19 00000058
E 23 00000070
E 22 00000068
E 26 000000C0

//--- project.f
+incdir+src
src/isa_pkg.sv
src/pipe_pkg.sv
src/rf_write_if.sv
src/fetch_stage.sv
src/decode_stage.sv
src/execute_stage.sv
src/memory_stage.sv
src/riscv_cpu.sv
testbench/tb_riscv_cpu.sv

//--- run.sh
#!/bin/sh
# compile with verilator, run, and pass only if the pass line shows up
cd "$(dirname "$0")" &&
verilator --binary --timing --timescale 1ns/1ps -f project.f --top-module tb_riscv_cpu &&
./obj_dir/Vtb_riscv_cpu 2>&1 | tee /dev/stderr | grep -q "Simulation PASSED" &&
exit 0 || exit 1
